//--- verilog/host_pkg.sv
// Host I/O widths, register address map, enable bit indices, command and response structs
package host_pkg;

  // Command and response field widths
  localparam int io_addr_width = 16;
  localparam int io_data_width = 64;

  // Positions of the trace and profile enables in the enable register
  typedef enum int
  {
    e_en_icache    = 0,
    e_en_dcache    = 1,
    e_en_lce       = 2,
    e_en_cce       = 3,
    e_en_dram      = 4,
    e_en_vm        = 5,
    e_en_cmt       = 6,
    e_en_core_prof = 7,
    e_en_pc_prof   = 8,
    e_en_br_prof   = 9,
    e_en_cosim     = 10
  } host_enable_e;

  localparam int num_enables = 11;

  // Register address map
  localparam logic [io_addr_width-1:0] enable_addr    = 16'h0000;
  localparam logic [io_addr_width-1:0] finish_addr    = 16'h0008;
  localparam logic [io_addr_width-1:0] heartbeat_addr = 16'h0010;
  localparam logic [io_addr_width-1:0] putchar_addr   = 16'h0018;

  // One command from the core, 81 bits
  typedef struct packed
  {
    logic                     we;
    logic [io_addr_width-1:0] addr;
    logic [io_data_width-1:0] data;
  } host_cmd_s;

  // One response to the core, 80 bits
  typedef struct packed
  {
    logic [io_addr_width-1:0] addr;
    logic [io_data_width-1:0] data;
  } host_resp_s;

endpackage

//--- verilog/io_fifo.sv
// Small circular-buffer FIFO with a type-parameterized payload
module io_fifo
  #(parameter type payload_t = logic
    , parameter int depth_p = 2
    )
  (input  logic     clk_i
   , input  logic     arst_n_i
   , input  logic     v_i
   , input  payload_t data_i
   , output logic     ready_o
   , output logic     v_o
   , output payload_t data_o
   , input  logic     yumi_i
   );

  localparam int ptr_width_lp = (depth_p > 1) ? $clog2(depth_p) : 1;
  localparam int cnt_width_lp = $clog2(depth_p + 1);

  payload_t mem_r [depth_p];

  logic [ptr_width_lp-1:0] rptr_r, wptr_r;
  logic [cnt_width_lp-1:0] count_r;
  logic push, pop, full;

  assign full    = (count_r == cnt_width_lp'(depth_p));
  assign v_o     = (count_r != '0);
  // A pop frees the head slot, so a full FIFO still takes a push
  assign ready_o = ~full | yumi_i;
  assign push    = v_i & ready_o;
  assign pop     = yumi_i & v_o;
  assign data_o  = mem_r[rptr_r];

  always_ff @(posedge clk_i)
  begin
    if (push)
    begin
      mem_r[wptr_r] <= data_i;
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      rptr_r  <= '0;
      wptr_r  <= '0;
      count_r <= '0;
    end
    else
    begin
      if (push)
      begin
        wptr_r <= (wptr_r == ptr_width_lp'(depth_p - 1)) ? '0 : wptr_r + 1'b1;
      end
      if (pop)
      begin
        rptr_r <= (rptr_r == ptr_width_lp'(depth_p - 1)) ? '0 : rptr_r + 1'b1;
      end
      count_r <= count_r + cnt_width_lp'(push) - cnt_width_lp'(pop);
    end
  end

endmodule

//--- verilog/host_cmd_fsm.sv
// Command decode FSM: pops commands, drives register strobes, pushes responses
module host_cmd_fsm
  import host_pkg::*;
  (input  logic                     clk_i
   , input  logic                     arst_n_i

   // Command FIFO side, valid/yumi
   , input  logic                     cmd_v_i
   , input  host_cmd_s                cmd_i
   , output logic                     cmd_yumi_o

   // Response FIFO side, valid/ready
   , input  logic                     resp_ready_i
   , output logic                     resp_v_o
   , output host_resp_s               resp_o

   // Register block
   , output logic [io_addr_width-1:0] reg_addr_o
   , output logic [io_data_width-1:0] reg_wdata_o
   , output logic                     reg_we_o
   , input  logic [io_data_width-1:0] reg_rdata_i
   );

  typedef enum logic
  {
    e_decode,
    e_respond
  } state_e;

  state_e state_r, state_n;
  host_resp_s resp_r;
  logic decode_fire;

  // A command is consumed only while no response is pending
  assign decode_fire = (state_r == e_decode) & cmd_v_i;

  assign cmd_yumi_o  = decode_fire;
  assign reg_addr_o  = cmd_i.addr;
  assign reg_wdata_o = cmd_i.data;
  assign reg_we_o    = decode_fire & cmd_i.we;

  assign resp_v_o = (state_r == e_respond);
  assign resp_o   = resp_r;

  always_comb
  begin
    state_n = state_r;
    case (state_r)
      e_decode:
      begin
        if (cmd_v_i)
        begin
          state_n = e_respond;
        end
      end
      e_respond:
      begin
        // Hold the response until the FIFO takes it
        if (resp_ready_i)
        begin
          state_n = e_decode;
        end
      end
      default:
      begin
        state_n = e_decode;
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      state_r <= e_decode;
    end
    else
    begin
      state_r <= state_n;
    end
  end

  // Read data is sampled in the decode cycle, before any write lands
  always_ff @(posedge clk_i)
  begin
    if (decode_fire)
    begin
      resp_r.addr <= cmd_i.addr;
      resp_r.data <= reg_rdata_i;
    end
  end

endmodule

//--- verilog/host_enable_regs.sv
// Enable, finish, putchar and heartbeat registers with address decode and read mux
module host_enable_regs
  import host_pkg::*;
  (input  logic                     clk_i
   , input  logic                     arst_n_i
   , input  logic [io_addr_width-1:0] addr_i
   , input  logic [io_data_width-1:0] wdata_i
   , input  logic                     we_i
   , output logic [io_data_width-1:0] rdata_o
   , output logic [num_enables-1:0]   enable_o
   , output logic                     finish_o
   , output logic                     char_v_o
   , output logic [7:0]               char_o
   , output logic                     heartbeat_o
   );

  logic [num_enables-1:0] enable_r;
  logic finish_r, char_v_r, heartbeat_r;
  logic [7:0] char_r;

  always_comb
  begin
    case (addr_i)
      enable_addr:    rdata_o = io_data_width'(enable_r);
      finish_addr:    rdata_o = io_data_width'(finish_r);
      heartbeat_addr: rdata_o = '0;
      putchar_addr:   rdata_o = '0;
      default:        rdata_o = '1;
    endcase
  end

  always_ff @(posedge clk_i or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      enable_r    <= '0;
      finish_r    <= 1'b0;
      char_v_r    <= 1'b0;
      heartbeat_r <= 1'b0;
    end
    else
    begin
      // Strobes last one cycle
      char_v_r    <= we_i & (addr_i == putchar_addr);
      heartbeat_r <= we_i & (addr_i == heartbeat_addr);
      if (we_i && (addr_i == enable_addr))
      begin
        enable_r <= wdata_i[num_enables-1:0];
      end
      // Sticky until reset
      if (we_i && (addr_i == finish_addr) && wdata_i[0])
      begin
        finish_r <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (we_i && (addr_i == putchar_addr))
    begin
      char_r <= wdata_i[7:0];
    end
  end

  assign enable_o    = enable_r;
  assign finish_o    = finish_r;
  assign char_v_o    = char_v_r;
  assign char_o      = char_r;
  assign heartbeat_o = heartbeat_r;

endmodule

//--- verilog/heartbeat_watchdog.sv
// No-progress watchdog: cycle counter cleared by heartbeats, sticky timeout flag
module heartbeat_watchdog
  #(parameter int timeout_cycles_p = 100000)
  (input  logic clk_i
   , input  logic arst_n_i
   , input  logic heartbeat_i
   , output logic timeout_o
   );

  localparam int cnt_width_lp = $clog2(timeout_cycles_p + 1);

  logic [cnt_width_lp-1:0] count_r;
  logic timeout_r;
  logic expired;

  assign expired = (count_r == cnt_width_lp'(timeout_cycles_p));

  always_ff @(posedge clk_i or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      count_r   <= '0;
      timeout_r <= 1'b0;
    end
    else
    begin
      if (heartbeat_i)
      begin
        count_r <= '0;
      end
      else if (!expired)
      begin
        count_r <= count_r + 1'b1;
      end
      // Once set, only reset clears it
      if (expired)
      begin
        timeout_r <= 1'b1;
      end
    end
  end

  assign timeout_o = timeout_r;

endmodule

//--- verilog/sim_host_top.sv
// Host I/O top level: command and response FIFOs, decode FSM, registers, watchdog
module sim_host_top
  import host_pkg::*;
  #(parameter int timeout_cycles_p = 100000
    , parameter int fifo_depth_p = 2
    )
  (input  logic                     clk_i
   , input  logic                     arst_n_i

   // Commands from the core, valid/ready
   , input  logic                     io_cmd_v_i
   , input  logic                     io_cmd_we_i
   , input  logic [io_addr_width-1:0] io_cmd_addr_i
   , input  logic [io_data_width-1:0] io_cmd_data_i
   , output logic                     io_cmd_ready_o

   // Responses to the core, valid/yumi
   , output logic                     io_resp_v_o
   , output logic [io_addr_width-1:0] io_resp_addr_o
   , output logic [io_data_width-1:0] io_resp_data_o
   , input  logic                     io_resp_yumi_i

   , output logic [num_enables-1:0]   enable_o
   , output logic                     finish_o
   , output logic                     char_v_o
   , output logic [7:0]               char_o
   , output logic                     timeout_o
   );

  host_cmd_s  cmd_li, cmd_lo;
  host_resp_s resp_li, resp_lo;
  logic cmd_v_lo, cmd_yumi_li;
  logic resp_v_li, resp_ready_lo;

  logic [io_addr_width-1:0] reg_addr;
  logic [io_data_width-1:0] reg_wdata, reg_rdata;
  logic reg_we;
  logic heartbeat;

  assign cmd_li.we   = io_cmd_we_i;
  assign cmd_li.addr = io_cmd_addr_i;
  assign cmd_li.data = io_cmd_data_i;

  io_fifo
    #(.payload_t(host_cmd_s)
      , .depth_p(fifo_depth_p)
      )
    i_cmd_fifo
    (.clk_i(clk_i)
     , .arst_n_i(arst_n_i)
     , .v_i(io_cmd_v_i)
     , .data_i(cmd_li)
     , .ready_o(io_cmd_ready_o)
     , .v_o(cmd_v_lo)
     , .data_o(cmd_lo)
     , .yumi_i(cmd_yumi_li)
     );

  host_cmd_fsm i_cmd_fsm
    (.clk_i(clk_i)
     , .arst_n_i(arst_n_i)
     , .cmd_v_i(cmd_v_lo)
     , .cmd_i(cmd_lo)
     , .cmd_yumi_o(cmd_yumi_li)
     , .resp_ready_i(resp_ready_lo)
     , .resp_v_o(resp_v_li)
     , .resp_o(resp_li)
     , .reg_addr_o(reg_addr)
     , .reg_wdata_o(reg_wdata)
     , .reg_we_o(reg_we)
     , .reg_rdata_i(reg_rdata)
     );

  io_fifo
    #(.payload_t(host_resp_s)
      , .depth_p(fifo_depth_p)
      )
    i_resp_fifo
    (.clk_i(clk_i)
     , .arst_n_i(arst_n_i)
     , .v_i(resp_v_li)
     , .data_i(resp_li)
     , .ready_o(resp_ready_lo)
     , .v_o(io_resp_v_o)
     , .data_o(resp_lo)
     , .yumi_i(io_resp_yumi_i)
     );

  assign io_resp_addr_o = resp_lo.addr;
  assign io_resp_data_o = resp_lo.data;

  host_enable_regs i_regs
    (.clk_i(clk_i)
     , .arst_n_i(arst_n_i)
     , .addr_i(reg_addr)
     , .wdata_i(reg_wdata)
     , .we_i(reg_we)
     , .rdata_o(reg_rdata)
     , .enable_o(enable_o)
     , .finish_o(finish_o)
     , .char_v_o(char_v_o)
     , .char_o(char_o)
     , .heartbeat_o(heartbeat)
     );

  heartbeat_watchdog
    #(.timeout_cycles_p(timeout_cycles_p))
    i_watchdog
    (.clk_i(clk_i)
     , .arst_n_i(arst_n_i)
     , .heartbeat_i(heartbeat)
     , .timeout_o(timeout_o)
     );

endmodule

//--- sim/sim_host_chk.sv
// Response handshake, reset state and character strobe assertions, bound into the top level
module sim_host_chk
  import host_pkg::*;
  (input  logic                   clk_i
   , input  logic                   arst_n_i
   , input  logic                   io_resp_v_o
   , input  logic                   io_resp_yumi_i
   , input  logic [num_enables-1:0] enable_o
   , input  logic                   char_v_o
   );
  timeunit 1ns;
  timeprecision 1ps;

  int assert_fails = 0;

  // Head entry stays offered until taken
  resp_v_hold: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    (io_resp_v_o && !io_resp_yumi_i) |=> io_resp_v_o)
    else
    begin
      assert_fails++;
      $error("response valid fell without yumi");
    end

  reset_enables: assert property (@(posedge clk_i) $rose(arst_n_i) |-> (enable_o == '0))
    else
    begin
      assert_fails++;
      $error("enables not cleared by reset");
    end

  char_single: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    char_v_o |=> !char_v_o)
    else
    begin
      assert_fails++;
      $error("char_v_o high for two cycles");
    end

endmodule

bind sim_host_top sim_host_chk i_chk
  (.clk_i(clk_i)
   , .arst_n_i(arst_n_i)
   , .io_resp_v_o(io_resp_v_o)
   , .io_resp_yumi_i(io_resp_yumi_i)
   , .enable_o(enable_o)
   , .char_v_o(char_v_o)
   );

//--- sim/sim_host_tb.sv
// Host I/O testbench: clock, reset, command table, random response back-pressure, scoreboard
module sim_host_tb
  import host_pkg::*;
  ();
  timeunit 1ns;
  timeprecision 1ps;

  // One table row: command, expected response data, drain and check after it
  typedef struct packed
  {
    logic                     we;
    logic [io_addr_width-1:0] addr;
    logic [io_data_width-1:0] data;
    logic [io_data_width-1:0] resp;
    logic                     sync;
  } stim_s;

  localparam int num_stim = 17;
  localparam logic [io_data_width-1:0] ones = '1;

  logic clk_i, arst_n_i, io_cmd_v_i, io_cmd_we_i, io_cmd_ready_o;
  logic [io_addr_width-1:0] io_cmd_addr_i, io_resp_addr_o;
  logic [io_data_width-1:0] io_cmd_data_i, io_resp_data_o;
  logic io_resp_v_o, io_resp_yumi_i, yumi_en, finish_o, char_v_o, timeout_o, exp_finish;
  logic [num_enables-1:0] enable_o, exp_enable;
  logic [7:0] char_o, last_char, exp_char;
  logic [31:0] rng;
  stim_s stim_table [num_stim];
  logic [io_addr_width-1:0] exp_addr_q [$];
  logic [io_data_width-1:0] exp_data_q [$];
  int errors = 0;
  int resp_cnt = 0;
  int char_cnt = 0;
  int exp_chars = 0;

  sim_host_top #(.timeout_cycles_p(40)) i_dut (.*);

  initial
  begin
    clk_i = 1'b0;
    forever #4 clk_i = ~clk_i;
  end

  function automatic logic [31:0] next_random(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    return y ^ (y << 5);
  endfunction

  task automatic report_error(input string msg);
    errors++;
    $display("[ERROR] %0t: %s", $time, msg);
  endtask

  task automatic abort_run(input string what);
    errors++;
    $display("Timeout: %s", what);
    $display("** FAIL **");
    $finish;
  endtask

  // Holds the command on the bus until the FIFO can take it at the next edge
  task automatic send_cmd(input stim_s s);
    int waited;
    waited = 0;
    @(posedge clk_i);
    io_cmd_v_i    <= 1'b1;
    io_cmd_we_i   <= s.we;
    io_cmd_addr_i <= s.addr;
    io_cmd_data_i <= s.data;
    @(negedge clk_i);
    while (!io_cmd_ready_o && waited < 100)
    begin
      @(negedge clk_i);
      waited++;
    end
    if (!io_cmd_ready_o)
      abort_run("command FIFO did not accept a command within 100 cycles");
    exp_addr_q.push_back(s.addr);
    exp_data_q.push_back(s.resp);
  endtask

  task automatic drain();
    int waited;
    waited = 0;
    @(posedge clk_i);
    io_cmd_v_i <= 1'b0;
    while (exp_addr_q.size() != 0 && waited < 200)
    begin
      @(negedge clk_i);
      waited++;
    end
    if (exp_addr_q.size() != 0)
      abort_run("outstanding responses did not arrive within 200 cycles");
  endtask

  // Consumer only takes what is on offer
  assign io_resp_yumi_i = io_resp_v_o & yumi_en;

  initial
  begin
    rng = 32'h8996;
    yumi_en = 1'b0;
    forever
    begin
      @(posedge clk_i);
      rng = next_random(rng);
      yumi_en <= rng[0];
    end
  end

  // Responses leave at the next edge, so compare them at the falling one
  always @(negedge clk_i)
  begin
    if (arst_n_i && io_resp_v_o && io_resp_yumi_i)
    begin
      if (exp_addr_q.size() == 0)
        report_error($sformatf("response for 0x%h with no command outstanding", io_resp_addr_o));
      else
      begin
        if (io_resp_addr_o !== exp_addr_q[0] || io_resp_data_o !== exp_data_q[0])
          report_error($sformatf("response %0d is 0x%h/0x%h, expected 0x%h/0x%h", resp_cnt,
                                 io_resp_addr_o, io_resp_data_o, exp_addr_q[0], exp_data_q[0]));
        void'(exp_addr_q.pop_front());
        void'(exp_data_q.pop_front());
        resp_cnt++;
      end
    end
    if (char_v_o)
    begin
      char_cnt++;
      last_char = char_o;
    end
  end

  initial
  begin
    int i;
    time hb_time;
    arst_n_i      = 1'b0;
    io_cmd_v_i    = 1'b0;
    io_cmd_we_i   = 1'b0;
    io_cmd_addr_i = '0;
    io_cmd_data_i = '0;
    exp_enable    = '0;
    exp_finish    = 1'b0;
    exp_char      = 8'h00;
    hb_time       = 0;
    stim_table[0]  = '{1'b1, enable_addr,    64'h5A5, 64'h0,   1'b1};
    stim_table[1]  = '{1'b0, enable_addr,    64'h0,   64'h5A5, 1'b0};
    stim_table[2]  = '{1'b1, enable_addr,    ones,    64'h5A5, 1'b0};
    stim_table[3]  = '{1'b0, enable_addr,    64'h0,   64'h7FF, 1'b1};
    stim_table[4]  = '{1'b0, 16'h0040,       64'h0,   ones,    1'b0};
    stim_table[5]  = '{1'b1, 16'h0040,       64'h0,   ones,    1'b1};
    stim_table[6]  = '{1'b1, putchar_addr,   64'h41,  64'h0,   1'b1};
    stim_table[7]  = '{1'b1, finish_addr,    64'h1,   64'h0,   1'b0};
    stim_table[8]  = '{1'b0, finish_addr,    64'h0,   64'h1,   1'b1};
    // Burst of eight under random back-pressure
    stim_table[9]  = '{1'b1, enable_addr,    64'h123, 64'h7FF, 1'b0};
    stim_table[10] = '{1'b0, enable_addr,    64'h0,   64'h123, 1'b0};
    stim_table[11] = '{1'b0, heartbeat_addr, 64'h0,   64'h0,   1'b0};
    stim_table[12] = '{1'b1, putchar_addr,   64'h5A,  64'h0,   1'b0};
    stim_table[13] = '{1'b1, enable_addr,    64'h0,   64'h123, 1'b0};
    stim_table[14] = '{1'b0, finish_addr,    64'h0,   64'h1,   1'b0};
    stim_table[15] = '{1'b0, 16'h0100,       64'h0,   ones,    1'b0};
    stim_table[16] = '{1'b0, enable_addr,    64'h0,   64'h0,   1'b1};
    repeat (2) @(posedge clk_i);
    arst_n_i <= 1'b1;
    @(negedge clk_i);
    if (!io_cmd_ready_o || io_resp_v_o || char_v_o || finish_o || timeout_o || enable_o != '0)
      report_error("outputs are not in their reset state");

    // Heartbeats about every 20 cycles
    for (i = 0; i < 10; i++)
    begin
      send_cmd('{1'b1, heartbeat_addr, 64'h0, 64'h0, 1'b1});
      hb_time = $time;
      drain();
      repeat (14)
      begin
        @(negedge clk_i);
        if (timeout_o)
          report_error("watchdog fired while heartbeats were arriving");
      end
    end
    // Window starts at the last heartbeat command
    while (!timeout_o && ($time - hb_time) < 50 * 8)
    begin
      @(negedge clk_i);
    end
    if (!timeout_o)
      report_error("watchdog did not fire within 50 cycles of the last heartbeat");
    repeat (20)
    begin
      @(negedge clk_i);
      if (!timeout_o)
        report_error("watchdog flag cleared without reset");
    end

    for (i = 0; i < num_stim; i++)
    begin
      send_cmd(stim_table[i]);
      if (stim_table[i].we && stim_table[i].addr == enable_addr)
        exp_enable = stim_table[i].data[num_enables-1:0];
      if (stim_table[i].we && stim_table[i].addr == finish_addr && stim_table[i].data[0])
        exp_finish = 1'b1;
      if (stim_table[i].we && stim_table[i].addr == putchar_addr)
      begin
        exp_chars++;
        exp_char = stim_table[i].data[7:0];
      end
      if (stim_table[i].sync)
      begin
        drain();
        if (enable_o !== exp_enable)
          report_error($sformatf("row %0d: enable_o 0x%h, expected 0x%h", i, enable_o, exp_enable));
        if (finish_o !== exp_finish)
          report_error($sformatf("row %0d: finish_o %b, expected %b", i, finish_o, exp_finish));
        if (char_cnt != exp_chars || (exp_chars > 0 && last_char !== exp_char))
          report_error($sformatf("row %0d: %0d chars, last 0x%h, expected %0d, last 0x%h",
                                 i, char_cnt, last_char, exp_chars, exp_char));
      end
    end

    $display("Run done: %0d errors, %0d assertion failures, %0d responses",
             errors, i_dut.i_chk.assert_fails, resp_cnt);
    if (errors == 0 && i_dut.i_chk.assert_fails == 0)
      $display("** PASS **");
    else
      $display("** FAIL **");
    $finish;
  end

endmodule

//--- filelist.f
verilog/host_pkg.sv
verilog/io_fifo.sv
verilog/host_cmd_fsm.sv
verilog/host_enable_regs.sv
verilog/heartbeat_watchdog.sv
verilog/sim_host_top.sv
sim/sim_host_chk.sv
sim/sim_host_tb.sv

//--- run.sh
#!/usr/bin/env bash
# Compile the host I/O testbench with Verilator and run it
set -e
set -o pipefail

verilator --binary --timing --assert --timescale 1ns/1ps \
  --top-module sim_host_tb -f filelist.f -o sim_host_tb
./obj_dir/sim_host_tb | tee sim.log

if grep -qF '** FAIL **' sim.log; then
  echo "Simulation failed"
  exit 1
fi
echo "Simulation passed"
